// File: bench/cart_io_tests.txt
# op addr data expect (hex) | mw, iw write | mr read, expect = byte on cd_out
# ck: addr = megaram type, data = flags {scc,init,wstart,rstart,enabled}, expect = sector
# sd: addr = card type, data = {busy,-,-,-,-,-,timeout,crc}, expect = 1 pulses sd_done
ck 0000 00 00000000
mw 7E01 81 00
mw 7E03 AA 00
ck 0000 00 00000000
mr 7E02 00 FF
mw 7E00 01 00
mr 7E00 00 01
mw 7E03 78 00
mw 7E04 56 00
mw 7E05 34 00
mw 7E06 12 00
ck 0000 01 12345678
mw 7F06 FF 00
ck 0000 01 12345678
mr 7E10 00 FF
mw 7E01 81 00
ck 0000 0B 12345678
mw 7E01 02 00
ck 0000 0F 12345678
sd 0000 00 1
ck 0000 09 12345678
sd 0003 83 0
mr 7E02 00 83
mr 7E0F 00 03
sd 0002 01 0
mr 7E02 00 01
mr 7E0F 00 02
iw 008F 05 00
ck 0001 19 12345678
iw 008F 16 00
ck 0002 09 12345678
iw 008F 08 00
ck 0003 09 12345678
iw 0090 05 00
ck 0003 09 12345678
iw 008F 00 00
ck 0000 09 12345678

// File: flist.f
+incdir+source
source/msx_bus_pkg.sv
source/sdc_pkg.sv
source/bus_sampler.sv
source/access_decoder.sv
source/sdc_regs.sv
source/cart_io_top.sv
bench/clock_gen.sv
bench/tb_cart_io.sv

// File: Bender.yml
package:
  name: cart_io

sources:
  # design
  - include_dirs:
      - source
    files:
      - source/msx_bus_pkg.sv
      - source/sdc_pkg.sv
      - source/bus_sampler.sv
      - source/access_decoder.sv
      - source/sdc_regs.sv
      - source/cart_io_top.sv
  # testbench
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/tb_cart_io.sv

// File: bench/tb_cart_io.sv
module tb_cart_io
    import msx_bus_pkg::*;
    import sdc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD_NS   = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int FRAME_CYCLES    = 8;
    localparam int FRAMES_PER_STEP = 4;
    localparam int OE_WAIT_CYCLES  = 3 * FRAME_CYCLES;

    localparam bus_byte_t CTRL_MEM = 8'hFE;   // merq_n low, iorq_n and m1_n high
    localparam bus_byte_t CTRL_IO  = 8'hFD;   // iorq_n low

    logic          clk108_w;
    logic          reset_ram_n;
    bus_byte_t     mp;
    logic          rd_n;
    logic          wr_n;
    bus_byte_t     cd_in;
    logic          sd_busy;
    logic          sd_done;
    logic          sd_crc_error;
    logic          sd_timeout_error;
    card_type_t    sd_card_type;
    msel_t         msel_n;
    bus_byte_t     cd_out;
    logic          cd_oe;
    logic          sd_enabled;
    logic          sd_rstart;
    logic          sd_wstart;
    logic          sd_init;
    sd_sector_t    sd_sector;
    megaram_type_t megaram_type;
    logic          scc_enable;

    bus_addr_t     bus_addr;      // access the z80 model presents
    bus_byte_t     bus_ctrl;

    // test steps
    logic [31:0]   step_op[$];
    logic [15:0]   step_addr[$];
    logic [7:0]    step_data[$];
    logic [31:0]   step_exp[$];
    logic          steps_loaded;

    clock_gen u_clk (
        .clk108_w    (clk108_w),
        .reset_ram_n (reset_ram_n)
    );

    cart_io_top u_dut (
        .clk108_w         (clk108_w),
        .reset_ram_n      (reset_ram_n),
        .mp               (mp),
        .rd_n             (rd_n),
        .wr_n             (wr_n),
        .cd_in            (cd_in),
        .sd_busy          (sd_busy),
        .sd_done          (sd_done),
        .sd_crc_error     (sd_crc_error),
        .sd_timeout_error (sd_timeout_error),
        .sd_card_type     (sd_card_type),
        .msel_n           (msel_n),
        .cd_out           (cd_out),
        .cd_oe            (cd_oe),
        .sd_enabled       (sd_enabled),
        .sd_rstart        (sd_rstart),
        .sd_wstart        (sd_wstart),
        .sd_init          (sd_init),
        .sd_sector        (sd_sector),
        .megaram_type     (megaram_type),
        .scc_enable       (scc_enable)
    );

    ////////////////////////////////////////////////////////////
    // result checks

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string name, input bus_byte_t got, input bus_byte_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_sector(input string name, input sd_sector_t got,
                                input sd_sector_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_type(input string name, input megaram_type_t got,
                              input megaram_type_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_msel(input string name, input msel_t got, input msel_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // data file

    task automatic load_tests();
        int               fd;
        int               n;
        logic [31:0]      op_word;
        logic [15:0]      f_addr;
        logic [7:0]       f_data;
        logic [31:0]      f_exp;
        logic [8*128-1:0] line_buf;
        logic             at_end;
        fd = $fopen("bench/cart_io_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/cart_io_tests.txt");
            abort_run();
        end
        at_end = 1'b0;
        while (!at_end) begin
            n = $fscanf(fd, "%s", op_word);
            if (n != 1) begin
                at_end = 1'b1;
            end else if (op_word == "#") begin
                n = $fgets(line_buf, fd);     // rest of a comment line
            end else begin
                n = $fscanf(fd, "%h %h %h", f_addr, f_data, f_exp);
                if (n != 3) begin
                    $display("malformed test line after %0d steps", step_op.size());
                    abort_run();
                end
                step_op.push_back(op_word);
                step_addr.push_back(f_addr);
                step_data.push_back(f_data);
                step_exp.push_back(f_exp);
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // z80 bus model

    // mp answers whichever byte group msel_n asks for
    always @(negedge clk108_w) begin
        case (msel_n)
            3'b110:  mp = bus_addr[7:0];
            3'b101:  mp = bus_addr[15:8];
            3'b011:  mp = bus_ctrl;
            default: mp = 8'hFF;
        endcase
    end

    task automatic wait_idle_slot();
        @(negedge clk108_w);
        while (msel_n != 3'b111) @(negedge clk108_w);
    endtask

    // returns in the idle slot closing the n-th frame
    task automatic wait_frames(input int n);
        repeat (n) begin
            @(negedge clk108_w);
            while (msel_n == 3'b111) @(negedge clk108_w);
            while (msel_n != 3'b111) @(negedge clk108_w);
        end
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_byte_t ctrl,
                             input bus_byte_t data);
        wait_idle_slot();
        bus_addr = addr;
        bus_ctrl = ctrl;
        cd_in    = data;
        wr_n     = 1'b0;
        wait_frames(2);
        wr_n = 1'b1;
        wait_frames(2);
    endtask

    task automatic bus_read(input bus_addr_t addr, input bus_byte_t expected);
        int waited;
        wait_idle_slot();
        bus_addr = addr;
        bus_ctrl = CTRL_MEM;
        rd_n     = 1'b0;
        waited   = 0;
        @(negedge clk108_w);
        while (!cd_oe && waited < OE_WAIT_CYCLES) begin
            @(negedge clk108_w);
            waited++;
        end
        if (!cd_oe) begin
            $display("cd_oe never rose during the read of %h", addr);
            abort_run();
        end
        check_byte("cd_out", cd_out, expected);
        while (msel_n != 3'b111) @(negedge clk108_w);   // end of second frame
        rd_n = 1'b1;
        wait_frames(2);
        check_flag("cd_oe", cd_oe, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // sd engine model and output checks

    task automatic drive_sd_model(input logic [15:0] ctype, input logic [7:0] flags,
                                  input logic done);
        @(negedge clk108_w);
        sd_card_type     = ctype[1:0];
        sd_busy          = flags[7];
        sd_timeout_error = flags[1];
        sd_crc_error     = flags[0];
        sd_done          = done;
        @(negedge clk108_w);
        sd_done = 1'b0;
    endtask

    // flags: 0 enabled, 1 rstart, 2 wstart, 3 init, 4 scc
    task automatic check_outputs(input logic [15:0] mtype, input logic [7:0] flags,
                                 input logic [31:0] sector);
        @(negedge clk108_w);
        check_sector("sd_sector", sd_sector, sector);
        check_type("megaram_type", megaram_type, megaram_type_t'(mtype[1:0]));
        check_flag("sd_enabled", sd_enabled, flags[0]);
        check_flag("sd_rstart", sd_rstart, flags[1]);
        check_flag("sd_wstart", sd_wstart, flags[2]);
        check_flag("sd_init", sd_init, flags[3]);
        check_flag("scc_enable", scc_enable, flags[4]);
    endtask

    task automatic run_step(input int idx);
        case (step_op[idx])
            "mw":    bus_write(step_addr[idx], CTRL_MEM, step_data[idx]);
            "iw":    bus_write(step_addr[idx], CTRL_IO, step_data[idx]);
            "mr":    bus_read(step_addr[idx], step_exp[idx][7:0]);
            "sd":    drive_sd_model(step_addr[idx], step_data[idx], step_exp[idx][0]);
            "ck":    check_outputs(step_addr[idx], step_data[idx], step_exp[idx]);
            default: begin
                $display("unknown operation in test step %0d", idx);
                abort_run();
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////

    initial begin : main
        msel_t msel_seq[4];
        int    i;
        msel_seq         = '{3'b110, 3'b101, 3'b011, 3'b111};
        mp               = 8'hFF;
        rd_n             = 1'b1;
        wr_n             = 1'b1;
        cd_in            = 8'h00;
        sd_busy          = 1'b0;
        sd_done          = 1'b0;
        sd_crc_error     = 1'b0;
        sd_timeout_error = 1'b0;
        sd_card_type     = 2'd0;
        bus_addr         = 16'h0000;
        bus_ctrl         = 8'hFF;
        steps_loaded     = 1'b0;
        load_tests();
        steps_loaded = 1'b1;

        @(negedge clk108_w);     // still inside reset
        check_msel("msel_n", msel_n, 3'b111);
        check_flag("cd_oe", cd_oe, 1'b0);
        check_flag("sd_rstart", sd_rstart, 1'b0);
        check_flag("sd_wstart", sd_wstart, 1'b0);

        wait (reset_ram_n == 1'b1);
        for (i = 0; i < 2 * FRAME_CYCLES; i++) begin
            @(negedge clk108_w);
            check_msel("msel_n", msel_n, msel_seq[(i / 2) % 4]);
        end
        check_flag("cd_oe", cd_oe, 1'b0);

        for (i = 0; i < step_op.size(); i++) begin
            run_step(i);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin : watchdog
        int limit_ns;
        wait (steps_loaded);
        limit_ns = 2 * (step_op.size() * FRAMES_PER_STEP * FRAME_CYCLES * CLK_PERIOD_NS
                        + RESET_CYCLES * CLK_PERIOD_NS);
        #(limit_ns);
        $display("timeout after %0d ns, the test steps did not complete", limit_ns);
        abort_run();
    end

endmodule

// File: bench/clock_gen.sv
module clock_gen (
    output logic clk108_w,
    output logic reset_ram_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD_NS    = 20;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk108_w = 1'b0;
        forever #(PERIOD_NS / 2) clk108_w = ~clk108_w;
    end

    // released on a falling edge, clear of the capture edge
    initial begin
        reset_ram_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk108_w);
        reset_ram_n = 1'b1;
    end

endmodule

// File: source/cart_io_top.sv
module cart_io_top
    import msx_bus_pkg::*;
    import sdc_pkg::*;
(
    input  logic          clk108_w,
    input  logic          reset_ram_n,
    input  bus_byte_t     mp,
    input  logic          rd_n,
    input  logic          wr_n,
    input  bus_byte_t     cd_in,
    input  logic          sd_busy,
    input  logic          sd_done,
    input  logic          sd_crc_error,
    input  logic          sd_timeout_error,
    input  card_type_t    sd_card_type,
    output msel_t         msel_n,
    output bus_byte_t     cd_out,
    output logic          cd_oe,
    output logic          sd_enabled,
    output logic          sd_rstart,
    output logic          sd_wstart,
    output logic          sd_init,
    output sd_sector_t    sd_sector,
    output megaram_type_t megaram_type,
    output logic          scc_enable
);

    // sampled access record
    logic      acc_valid;
    bus_addr_t acc_addr;
    logic      acc_iorq_n;
    logic      acc_merq_n;
    logic      acc_m1_n;
    logic      acc_rd_n;
    logic      acc_wr_n;
    logic      acc_end;

    // wishbone between decoder and register bank
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    wb_addr_t  wb_adr;
    bus_byte_t wb_dat_w;
    logic      wb_ack;
    bus_byte_t wb_dat_r;

    bus_sampler u_sampler (
        .clk108_w    (clk108_w),
        .reset_ram_n (reset_ram_n),
        .mp          (mp),
        .rd_n        (rd_n),
        .wr_n        (wr_n),
        .msel_n      (msel_n),
        .acc_valid   (acc_valid),
        .acc_addr    (acc_addr),
        .acc_iorq_n  (acc_iorq_n),
        .acc_merq_n  (acc_merq_n),
        .acc_m1_n    (acc_m1_n),
        .acc_rd_n    (acc_rd_n),
        .acc_wr_n    (acc_wr_n),
        .acc_end     (acc_end)
    );

    access_decoder u_decoder (
        .clk108_w    (clk108_w),
        .reset_ram_n (reset_ram_n),
        .acc_valid   (acc_valid),
        .acc_addr    (acc_addr),
        .acc_iorq_n  (acc_iorq_n),
        .acc_merq_n  (acc_merq_n),
        .acc_m1_n    (acc_m1_n),
        .acc_rd_n    (acc_rd_n),
        .acc_wr_n    (acc_wr_n),
        .acc_end     (acc_end),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .cd_in       (cd_in),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .cd_out      (cd_out),
        .cd_oe       (cd_oe)
    );

    sdc_regs u_regs (
        .clk108_w         (clk108_w),
        .reset_ram_n      (reset_ram_n),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_we            (wb_we),
        .wb_adr           (wb_adr),
        .wb_dat_w         (wb_dat_w),
        .sd_busy          (sd_busy),
        .sd_done          (sd_done),
        .sd_crc_error     (sd_crc_error),
        .sd_timeout_error (sd_timeout_error),
        .sd_card_type     (sd_card_type),
        .wb_ack           (wb_ack),
        .wb_dat_r         (wb_dat_r),
        .sd_enabled       (sd_enabled),
        .sd_rstart        (sd_rstart),
        .sd_wstart        (sd_wstart),
        .sd_init          (sd_init),
        .sd_sector        (sd_sector),
        .megaram_type     (megaram_type),
        .scc_enable       (scc_enable)
    );

endmodule

// File: source/sdc_regs.sv
`include "cart_params.svh"

module sdc_regs
    import sdc_pkg::*;
(
    input  logic          clk108_w,
    input  logic          reset_ram_n,
    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  wb_addr_t      wb_adr,
    input  logic [7:0]    wb_dat_w,
    input  logic          sd_busy,
    input  logic          sd_done,
    input  logic          sd_crc_error,
    input  logic          sd_timeout_error,
    input  card_type_t    sd_card_type,
    output logic          wb_ack,
    output logic [7:0]    wb_dat_r,
    output logic          sd_enabled,
    output logic          sd_rstart,
    output logic          sd_wstart,
    output logic          sd_init,
    output sd_sector_t    sd_sector,
    output megaram_type_t megaram_type,
    output logic          scc_enable
);

    logic        req;         // strobe seen, not yet acked
    logic        io_space;
    logic [7:0]  offset;
    logic        mem_wr;
    logic        io_wr;
    logic [7:0]  rd_byte;
    sdc_status_t status;

    assign req      = wb_cyc && wb_stb && !wb_ack;
    assign io_space = wb_adr[8];
    assign offset   = wb_adr[7:0];
    assign mem_wr   = req && wb_we && !io_space;
    assign io_wr    = req && wb_we && io_space && (offset == `MEGARAM_PORT);

    assign status = '{busy: sd_busy, rsvd: 5'b0, timeout: sd_timeout_error,
                      crc: sd_crc_error};

    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    ////////////////////////////////////////////////////////////
    // sd control

    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            sd_enabled <= 1'b0;
            sd_rstart  <= 1'b0;
            sd_wstart  <= 1'b0;
            sd_init    <= 1'b0;
            sd_sector  <= '0;
        end else begin
            if (sd_done) begin
                sd_rstart <= 1'b0;   // init is sticky
                sd_wstart <= 1'b0;
            end
            if (mem_wr && offset == `SDC_ENABLE) begin
                sd_enabled <= wb_dat_w[0];
            end else if (mem_wr && sd_enabled) begin
                case (offset)
                    `SDC_CMD: begin
                        sd_rstart <= sd_rstart | wb_dat_w[0];
                        sd_wstart <= sd_wstart | wb_dat_w[1];
                        sd_init   <= sd_init   | wb_dat_w[7];
                    end
                    `SDC_SADDR + 8'd0: sd_sector[7:0]   <= wb_dat_w;
                    `SDC_SADDR + 8'd1: sd_sector[15:8]  <= wb_dat_w;
                    `SDC_SADDR + 8'd2: sd_sector[23:16] <= wb_dat_w;
                    `SDC_SADDR + 8'd3: sd_sector[31:24] <= wb_dat_w;
                    default: ;
                endcase
            end
        end
    end

    // readback, locked registers read as ff
    always_comb begin
        rd_byte = 8'hFF;
        if (!io_space) begin
            if (offset == `SDC_ENABLE) begin
                rd_byte = {7'b0, sd_enabled};
            end else if (sd_enabled) begin
                case (offset)
                    `SDC_STATUS: rd_byte = status;
                    `SDC_CTYPE:  rd_byte = {6'b0, sd_card_type};
                    default:     rd_byte = 8'hFF;
                endcase
            end
        end
    end

    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            wb_dat_r <= '0;
        end else if (req && !wb_we) begin
            wb_dat_r <= rd_byte;     // valid with ack
        end
    end

    ////////////////////////////////////////////////////////////
    // megaram config port

    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            megaram_type <= konami;
            scc_enable   <= 1'b0;
        end else if (io_wr) begin
            scc_enable <= (wb_dat_w == `MR_CODE_SCC);
            case (wb_dat_w)
                `MR_CODE_SCC:     megaram_type <= konami_scc;
                `MR_CODE_ASCII16: megaram_type <= ascii16;
                `MR_CODE_ASCII8:  megaram_type <= ascii8;
                default:          megaram_type <= konami;
            endcase
        end
    end

endmodule

// File: source/access_decoder.sv
`include "cart_params.svh"

module access_decoder
    import msx_bus_pkg::*;
    import sdc_pkg::*;
(
    input  logic      clk108_w,
    input  logic      reset_ram_n,
    input  logic      acc_valid,
    input  bus_addr_t acc_addr,
    input  logic      acc_iorq_n,
    input  logic      acc_merq_n,
    input  logic      acc_m1_n,
    input  logic      acc_rd_n,
    input  logic      acc_wr_n,
    input  logic      acc_end,
    input  logic      wb_ack,
    input  bus_byte_t wb_dat_r,
    input  bus_byte_t cd_in,
    output logic      wb_cyc,
    output logic      wb_stb,
    output logic      wb_we,
    output wb_addr_t  wb_adr,
    output bus_byte_t wb_dat_w,
    output bus_byte_t cd_out,
    output logic      cd_oe
);

    logic mem_hit;     // memory access inside the register page
    logic io_hit;      // config port write
    logic start;
    logic wb_busy;
    logic rd_done;

    assign mem_hit = !acc_merq_n && acc_iorq_n && acc_m1_n
                     && (acc_addr[15:8] == `SDC_PAGE);
    assign io_hit  = !acc_iorq_n && acc_m1_n && !acc_wr_n
                     && (acc_addr[7:0] == `MEGARAM_PORT);
    assign start   = acc_valid && (mem_hit || io_hit);
    assign rd_done = wb_busy && wb_ack && !wb_we;

    assign wb_cyc = wb_busy;
    assign wb_stb = wb_busy;

    ////////////////////////////////////////////////////////////
    // wishbone master, one transfer per access

    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            wb_busy <= 1'b0;
            cd_oe   <= 1'b0;
        end else begin
            if (start) begin
                wb_busy <= 1'b1;
            end else if (wb_busy && wb_ack) begin
                wb_busy <= 1'b0;
            end
            if (acc_end) begin
                cd_oe <= 1'b0;
            end else if (rd_done) begin
                cd_oe <= 1'b1;       // drive bus until the z80 lets go
            end
        end
    end

    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            wb_we    <= 1'b0;
            wb_adr   <= '0;
            wb_dat_w <= '0;
            cd_out   <= '0;
        end else begin
            if (start) begin
                wb_we    <= !acc_wr_n;
                wb_adr   <= {io_hit, acc_addr[7:0]};
                wb_dat_w <= cd_in;
            end
            if (rd_done) begin
                cd_out <= wb_dat_r;
            end
        end
    end

endmodule

// File: source/bus_sampler.sv
module bus_sampler
    import msx_bus_pkg::*;
(
    input  logic      clk108_w,
    input  logic      reset_ram_n,
    input  bus_byte_t mp,
    input  logic      rd_n,
    input  logic      wr_n,
    output msel_t     msel_n,
    output logic      acc_valid,
    output bus_addr_t acc_addr,
    output logic      acc_iorq_n,
    output logic      acc_merq_n,
    output logic      acc_m1_n,
    output logic      acc_rd_n,
    output logic      acc_wr_n,
    output logic      acc_end
);

    dot_phase_t phase;
    bus_byte_t  addr_lo;
    bus_byte_t  addr_hi;
    logic       last_idle;    // previous frame had no rd or wr strobe
    logic       frame_idle;

    assign frame_idle = rd_n & wr_n;

    ////////////////////////////////////////////////////////////
    // dot sequencer

    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            phase <= 3'd7;    // parks msel_n at none
        end else begin
            phase <= phase + 3'd1;
        end
    end

    // two cycles per byte group, last pair idle
    always_comb begin
        case (phase[2:1])
            2'b00:   msel_n = MSEL_ADDR_LO;
            2'b01:   msel_n = MSEL_ADDR_HI;
            2'b10:   msel_n = MSEL_CTRL;
            default: msel_n = MSEL_NONE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // byte capture

    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            addr_lo  <= '0;
            addr_hi  <= '0;
            acc_addr <= '0;
        end else begin
            if (phase == PH_CAP_LO) begin
                addr_lo <= mp;
            end
            if (phase == PH_CAP_HI) begin
                addr_hi <= mp;
            end
            if (phase == PH_CAP_CTRL) begin
                acc_addr <= {addr_hi, addr_lo};
            end
        end
    end

    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            acc_merq_n <= 1'b1;
            acc_iorq_n <= 1'b1;
            acc_m1_n   <= 1'b1;
            acc_rd_n   <= 1'b1;
            acc_wr_n   <= 1'b1;
            last_idle  <= 1'b1;
            acc_valid  <= 1'b0;
            acc_end    <= 1'b0;
        end else begin
            acc_valid <= 1'b0;
            acc_end   <= 1'b0;
            if (phase == PH_CAP_CTRL) begin
                acc_merq_n <= mp[CTL_MERQ_BIT];
                acc_iorq_n <= mp[CTL_IORQ_BIT];
                acc_m1_n   <= mp[CTL_M1_BIT];
                acc_rd_n   <= rd_n;
                acc_wr_n   <= wr_n;
                last_idle  <= frame_idle;
                // one record on the first busy frame, one end on the first idle one
                acc_valid  <= !frame_idle && last_idle;
                acc_end    <= frame_idle && !last_idle;
            end
        end
    end

endmodule

// File: source/sdc_pkg.sv
package sdc_pkg;

    // bit 8 set for i/o space, low byte is the offset or the port
    typedef logic [8:0] wb_addr_t;

    typedef enum logic [1:0] {
        konami     = 2'd0,
        konami_scc = 2'd1,
        ascii16    = 2'd2,
        ascii8     = 2'd3
    } megaram_type_t;

    typedef logic [31:0] sd_sector_t;

    typedef logic [1:0] card_type_t;   // 0 unknown, 1 sdv1, 2 sdv2, 3 sdhc

    // layout of the STATUS readback
    typedef struct packed {
        logic       busy;
        logic [4:0] rsvd;
        logic       timeout;
        logic       crc;
    } sdc_status_t;

endpackage

// File: source/msx_bus_pkg.sv
package msx_bus_pkg;

    typedef logic [15:0] bus_addr_t;   // z80 address
    typedef logic [7:0]  bus_byte_t;
    typedef logic [2:0]  dot_phase_t;  // eight phases per frame
    typedef logic [2:0]  msel_t;       // active low, one bit per byte group

    // mux select per byte group on mp
    localparam msel_t MSEL_ADDR_LO = 3'b110;   // a0-a7
    localparam msel_t MSEL_ADDR_HI = 3'b101;   // a8-a15
    localparam msel_t MSEL_CTRL    = 3'b011;   // control strobes
    localparam msel_t MSEL_NONE    = 3'b111;

    // control byte layout
    localparam int CTL_MERQ_BIT = 0;
    localparam int CTL_IORQ_BIT = 1;
    localparam int CTL_M1_BIT   = 7;

    // phases whose last cycle latches mp
    localparam dot_phase_t PH_CAP_LO   = 3'd1;
    localparam dot_phase_t PH_CAP_HI   = 3'd3;
    localparam dot_phase_t PH_CAP_CTRL = 3'd5;

endpackage

// File: source/cart_params.svh
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

////////////////////////////////////////////////////////////
// sd controller register window, 7E00h-7EFFh

`define SDC_PAGE          8'h7E     // upper address byte of the window

`define SDC_ENABLE        8'h00     // rw, bit 0 unlocks the rest
`define SDC_CMD           8'h01     // wo, rstart / wstart / init
`define SDC_STATUS        8'h02     // ro, busy and error flags
`define SDC_SADDR         8'h03     // wo, 4 bytes of sector, lsb first
`define SDC_CTYPE         8'h0F     // ro, card type

////////////////////////////////////////////////////////////
// megaram mapper configuration

`define MEGARAM_PORT      8'h8F     // i/o port

`define MR_CODE_SCC       8'h05
`define MR_CODE_ASCII16   8'h16
`define MR_CODE_ASCII8    8'h08
// any other code selects plain konami

`endif
